/* filelist.f */
src/dataCachePkg.sv
src/cacheController.sv
src/cacheArray.sv
src/dataCache.sv
sim/memoryModel.sv
sim/dataCacheMonitor.sv
sim/dataCache_checker.sv
sim/dataCacheTb.sv

/* run.sh */
#!/bin/bash
# build and run the data cache testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module dataCacheTb -f filelist.f \
	-o dataCacheSim > build.log 2>&1 \
	&& ./obj_dir/dataCacheSim > sim.log 2>&1 \
	|| { echo "build or simulation failed, see build.log and sim.log"; exit 1; }
grep -q "^TEST PASS$" sim.log && echo "simulation passed" \
	|| { echo "simulation failed, see sim.log"; exit 1; }

/* sim/dataCacheTb.sv */
`timescale 1ns/1ps

module dataCacheTb;

	import dataCachePkg::*;

	localparam logic [1:0] opIdle = 2'd0;
	localparam logic [1:0] opRead = 2'd1;
	localparam logic [1:0] opWrite = 2'd2;
	localparam int maxSteps = 32;
	localparam int timeoutCycles = 200;

	logic clock;
	logic reset;
	logic ren;
	logic wen;
	logic [wordBits-1:0] addr;
	logic [byteLanes-1:0] byteSelect;
	logic [wordBits-1:0] din;
	logic stall;
	logic [wordBits-1:0] dout;
	logic memRen;
	logic memWen;
	logic memReadReady;
	logic memWriteDone;
	logic [blockAddrBits-1:0] memBlockAddr;
	blockData memDin;
	blockData memDout;
	logic expectValid;
	logic [wordBits-1:0] expectData;
	int errorCount;
	int writebackCount;
	int timeoutCount;
	int trafficErrors;
	int stepCount;

	// stimulus table
	logic [1:0] opList [maxSteps];
	logic [wordBits-1:0] addrList [maxSteps];
	logic [byteLanes-1:0] selectList [maxSteps];
	logic [wordBits-1:0] dataList [maxSteps];
	logic [wordBits-1:0] expectList [maxSteps];

	dataCache dataCache_i (
		.clock        (clock),
		.reset        (reset),
		.ren          (ren),
		.wen          (wen),
		.addr         (addr),
		.byteSelect   (byteSelect),
		.din          (din),
		.stall        (stall),
		.dout         (dout),
		.memRen       (memRen),
		.memWen       (memWen),
		.memBlockAddr (memBlockAddr),
		.memDin       (memDin),
		.memReadReady (memReadReady),
		.memWriteDone (memWriteDone),
		.memDout      (memDout)
	);

	memoryModel memory_i (
		.clock        (clock),
		.reset        (reset),
		.memRen       (memRen),
		.memWen       (memWen),
		.memBlockAddr (memBlockAddr),
		.memDin       (memDin),
		.memReadReady (memReadReady),
		.memWriteDone (memWriteDone),
		.memDout      (memDout)
	);

	dataCacheMonitor monitor_i (
		.clock          (clock),
		.reset          (reset),
		.ren            (ren),
		.wen            (wen),
		.addr           (addr),
		.byteSelect     (byteSelect),
		.din            (din),
		.stall          (stall),
		.dout           (dout),
		.memRen         (memRen),
		.memWen         (memWen),
		.memWriteDone   (memWriteDone),
		.memBlockAddr   (memBlockAddr),
		.memDin         (memDin),
		.expectValid    (expectValid),
		.expectData     (expectData),
		.errorCount     (errorCount),
		.writebackCount (writebackCount)
	);

	initial begin
		clock = 1'b0;
		forever #10 clock = ~clock;
	end

	// memory content before any write
	function automatic logic [31:0] initWord(input logic [31:0] byteAddr);
		return byteAddr ^ 32'hA5A50000;
	endfunction

	function automatic logic [31:0] mergeBytes(input logic [31:0] oldWord,
		input logic [31:0] newWord, input logic [3:0] sel);
		logic [31:0] result;
		result = oldWord;
		for (int lane = 0; lane < 4; lane++) begin
			if (sel[lane]) begin
				result[8 * lane +: 8] = newWord[8 * lane +: 8];
			end
		end
		return result;
	endfunction

	task automatic addStep(input logic [1:0] op, input logic [31:0] a, input logic [3:0] sel,
		input logic [31:0] data, input logic [31:0] expected);
		opList[stepCount] = op;
		addrList[stepCount] = a;
		selectList[stepCount] = sel;
		dataList[stepCount] = data;
		expectList[stepCount] = expected;
		stepCount++;
	endtask

	initial begin : stimulus
		int waited;
		int assertionErrors;
		logic done;
		logic [31:0] stride;
		logic [31:0] merged14;
		logic [31:0] merged224;
		logic [31:0] mergedConflict;
		reset = 1'b0;
		ren = 1'b0;
		wen = 1'b0;
		addr = '0;
		byteSelect = '0;
		din = '0;
		expectValid = 1'b0;
		expectData = '0;
		stepCount = 0;
		timeoutCount = 0;
		trafficErrors = 0;
		// same index, next tag
		stride = 32'd1 << (dataCache_i.indexBits + offsetBits);
		merged14 = mergeBytes(initWord(32'h014), 32'h11223344, 4'b0101);
		merged224 = mergeBytes(initWord(32'h224), 32'h77000000, 4'b1000);
		mergedConflict = mergeBytes(initWord(32'h224 + stride), 32'h0000CAFE, 4'b0011);
		addStep(opIdle, 32'h0, 4'h0, 32'h0, 32'h0);
		addStep(opIdle, 32'h0, 4'h0, 32'h0, 32'h0);
		addStep(opRead, 32'h010, 4'hF, 32'h0, initWord(32'h010));
		addStep(opRead, 32'h010, 4'hF, 32'h0, initWord(32'h010));
		addStep(opRead, 32'h014, 4'hF, 32'h0, initWord(32'h014));
		addStep(opWrite, 32'h014, 4'b0101, 32'h11223344, 32'h0);
		addStep(opRead, 32'h014, 4'hF, 32'h0, merged14);
		addStep(opWrite, 32'h018, 4'b1111, 32'hDEADBEEF, 32'h0);
		// evicts the dirty line
		addStep(opRead, 32'h010 + stride, 4'hF, 32'h0, initWord(32'h010 + stride));
		addStep(opRead, 32'h014, 4'hF, 32'h0, merged14);
		addStep(opRead, 32'h018, 4'hF, 32'h0, 32'hDEADBEEF);
		addStep(opWrite, 32'h224, 4'b1000, 32'h77000000, 32'h0);
		addStep(opRead, 32'h224, 4'hF, 32'h0, merged224);
		addStep(opWrite, 32'h224 + stride, 4'b0011, 32'h0000CAFE, 32'h0);
		addStep(opRead, 32'h224 + stride, 4'hF, 32'h0, mergedConflict);
		addStep(opRead, 32'h224, 4'hF, 32'h0, merged224);
		addStep(opRead, 32'h224 + stride, 4'hF, 32'h0, mergedConflict);
		addStep(opIdle, 32'h0, 4'h0, 32'h0, 32'h0);

		repeat (4) @(posedge clock);
		reset <= 1'b1;
		for (int i = 0; i < stepCount && timeoutCount == 0; i++) begin
			ren <= opList[i] == opRead;
			wen <= opList[i] == opWrite;
			addr <= addrList[i];
			byteSelect <= selectList[i];
			din <= dataList[i];
			expectValid <= opList[i] == opRead;
			expectData <= expectList[i];
			waited = 0;
			done = 1'b0;
			while (!done && waited < timeoutCycles) begin
				@(posedge clock);
				waited++;
				done = !stall;
			end
			if (!done) begin
				$display("request never completed: step %0d, address 0x%08h, %0d cycles",
					i, addrList[i], waited);
				timeoutCount++;
			end
		end
		ren <= 1'b0;
		wen <= 1'b0;
		expectValid <= 1'b0;
		@(posedge clock);
		if (writebackCount == 0) begin
			$display("no writeback of a dirty line was seen on the memory bus");
			trafficErrors++;
		end
		assertionErrors = dataCache_i.dataCache_checker_i.failCount;
		$display("errors: compare %0d, timeout %0d, traffic %0d, assertion %0d",
			errorCount, timeoutCount, trafficErrors, assertionErrors);
		if (errorCount + timeoutCount + trafficErrors + assertionErrors == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

/* sim/dataCache_checker.sv */
`timescale 1ns/1ps

module dataCache_checker (
	input  logic clock,
	input  logic reset,
	input  logic stall,
	input  logic memRen,
	input  logic memWen,
	input  logic [dataCachePkg::blockAddrBits-1:0] memBlockAddr
);

	// failed assertions, read by the testbench top
	int failCount = 0;

	// one memory request at a time
	assert property (@(posedge clock) disable iff (!reset) !(memRen && memWen))
		else begin
			$error("memRen and memWen high together");
			failCount++;
		end

	assert property (@(posedge clock) disable iff (!reset) (memRen || memWen) |-> stall)
		else begin
			$error("memory request while the pipeline is not stalled");
			failCount++;
		end

	// block address held for the whole request
	assert property (@(posedge clock) disable iff (!reset)
		((memRen && $past(memRen)) || (memWen && $past(memWen))) |-> $stable(memBlockAddr))
		else begin
			$error("memBlockAddr changed during a memory request");
			failCount++;
		end

endmodule

bind dataCache dataCache_checker dataCache_checker_i (
	.clock        (clock),
	.reset        (reset),
	.stall        (stall),
	.memRen       (memRen),
	.memWen       (memWen),
	.memBlockAddr (memBlockAddr)
);

/* sim/dataCacheMonitor.sv */
`timescale 1ns/1ps

module dataCacheMonitor (
	input  logic clock,
	input  logic reset,
	input  logic ren,
	input  logic wen,
	input  logic [dataCachePkg::wordBits-1:0] addr,
	input  logic [dataCachePkg::byteLanes-1:0] byteSelect,
	input  logic [dataCachePkg::wordBits-1:0] din,
	input  logic stall,
	input  logic [dataCachePkg::wordBits-1:0] dout,
	input  logic memRen,
	input  logic memWen,
	input  logic memWriteDone,
	input  logic [dataCachePkg::blockAddrBits-1:0] memBlockAddr,
	input  dataCachePkg::blockData memDin,
	input  logic expectValid,
	input  logic [dataCachePkg::wordBits-1:0] expectData,
	output int errorCount,
	output int writebackCount
);

	import dataCachePkg::*;

	// memory as the pipeline sees it
	logic [wordBits-1:0] shadow [256];
	logic [7:0] wordIndex;

	task automatic report(input string msg);
		$display("ERROR %0t: %s", $time, msg);
		errorCount++;
	endtask

	initial begin
		errorCount = 0;
		writebackCount = 0;
		for (int i = 0; i < 256; i++) begin
			shadow[i] = 32'(i * byteLanes) ^ 32'hA5A50000;
		end
	end

	always @(posedge clock) begin
		if (reset) begin
			if (!ren && !wen && (stall || memRen || memWen)) begin
				report("stall or memory request without a pipeline request");
			end
			if (memRen && memBlockAddr != addr[wordBits-1:offsetBits]) begin
				report($sformatf("fetch of block 0x%07h for address 0x%08h", memBlockAddr, addr));
			end
			if (ren && !stall && dout != shadow[addr[9:2]]) begin
				report($sformatf("read 0x%08h got 0x%08h, memory holds 0x%08h",
					addr, dout, shadow[addr[9:2]]));
			end
			if (ren && !stall && expectValid && dout != expectData) begin
				report($sformatf("read 0x%08h got 0x%08h, table expects 0x%08h",
					addr, dout, expectData));
			end
			if (memWen && memWriteDone) begin
				writebackCount++;
				if (memBlockAddr == addr[wordBits-1:offsetBits]) begin
					report("writeback of the requested block");
				end
				for (int w = 0; w < blockWords; w++) begin
					wordIndex = {memBlockAddr[5:0], 2'(w)};
					if (memDin.words[w] != shadow[wordIndex]) begin
						report($sformatf("writeback word %0d of block 0x%07h is 0x%08h, expected 0x%08h",
							w, memBlockAddr, memDin.words[w], shadow[wordIndex]));
					end
				end
			end
			// completed write
			if (wen && !stall) begin
				for (int lane = 0; lane < byteLanes; lane++) begin
					if (byteSelect[lane]) begin
						shadow[addr[9:2]][8 * lane +: 8] = din[8 * lane +: 8];
					end
				end
			end
		end
	end

endmodule

/* sim/memoryModel.sv */
`timescale 1ns/1ps

module memoryModel (
	input  logic clock,
	input  logic reset,
	input  logic memRen,
	input  logic memWen,
	input  logic [dataCachePkg::blockAddrBits-1:0] memBlockAddr,
	input  dataCachePkg::blockData memDin,
	output logic memReadReady,
	output logic memWriteDone,
	output dataCachePkg::blockData memDout
);

	import dataCachePkg::*;

	localparam int memWords = 256;

	logic [wordBits-1:0] memArray [memWords];
	logic [31:0] rngState;
	logic busy;
	int waitCount;
	logic [7:0] wordIndex;

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// each word starts as its byte address mixed with a constant
	initial begin
		for (int i = 0; i < memWords; i++) begin
			memArray[i] = 32'(i * byteLanes) ^ 32'hA5A50000;
		end
	end

	always @(posedge clock or negedge reset) begin
		if (!reset) begin
			rngState <= 32'd25;
			busy <= 1'b0;
			waitCount <= 0;
			memReadReady <= 1'b0;
			memWriteDone <= 1'b0;
			memDout <= '0;
		end else begin
			memReadReady <= 1'b0;
			memWriteDone <= 1'b0;
			// skip the edge where a response pulse is still visible
			if (!memReadReady && !memWriteDone) begin
				if (busy && waitCount == 1) begin
					busy <= 1'b0;
					for (int w = 0; w < blockWords; w++) begin
						wordIndex = {memBlockAddr[5:0], 2'(w)};
						if (memRen) begin
							memDout.words[w] <= memArray[wordIndex];
						end else begin
							memArray[wordIndex] <= memDin.words[w];
						end
					end
					memReadReady <= memRen;
					memWriteDone <= memWen;
				end else if (busy) begin
					waitCount <= waitCount - 1;
				end else if (memRen || memWen) begin
					// latency of 1 to 6 cycles
					busy <= 1'b1;
					rngState <= xorshift(rngState);
					waitCount <= int'(xorshift(rngState) % 32'd6) + 1;
				end
			end
		end
	end

endmodule

/* src/dataCache.sv */
`timescale 1ns/1ps

module dataCache #(
	parameter int indexBits = 4
) (
	input  logic clock,
	input  logic reset,

	// pipeline in
	input  logic ren,
	input  logic wen,
	input  logic [dataCachePkg::wordBits-1:0] addr,
	input  logic [dataCachePkg::byteLanes-1:0] byteSelect,
	input  logic [dataCachePkg::wordBits-1:0] din,

	// pipeline out
	output logic stall,
	output logic [dataCachePkg::wordBits-1:0] dout,

	// memory out
	output logic memRen,
	output logic memWen,
	output logic [dataCachePkg::blockAddrBits-1:0] memBlockAddr,
	output dataCachePkg::blockData memDin,

	// memory in
	input  logic memReadReady,
	input  logic memWriteDone,
	input  dataCachePkg::blockData memDout
);

	// array status to the controller
	logic cacheHit;
	logic cacheDirty;

	// controller strobes to the array
	logic writeBack;
	logic fillEn;

	cacheController cacheController_i (
		.clock        (clock),
		.reset        (reset),
		.ren          (ren),
		.wen          (wen),
		.cacheHit     (cacheHit),
		.cacheDirty   (cacheDirty),
		.memReadReady (memReadReady),
		.memWriteDone (memWriteDone),
		.stall        (stall),
		.memRen       (memRen),
		.memWen       (memWen),
		.writeBack    (writeBack),
		.fillEn       (fillEn)
	);

	cacheArray #(
		.indexBits (indexBits)
	) cacheArray_i (
		.clock        (clock),
		.reset        (reset),
		.ren          (ren),
		.wen          (wen),
		.addr         (addr),
		.byteSelect   (byteSelect),
		.din          (din),
		.fillEn       (fillEn),
		.writeBack    (writeBack),
		.memDout      (memDout),
		.cacheHit     (cacheHit),
		.cacheDirty   (cacheDirty),
		.dout         (dout),
		.memBlockAddr (memBlockAddr),
		.memDin       (memDin)
	);

endmodule

/* src/cacheArray.sv */
`timescale 1ns/1ps

module cacheArray #(
	parameter int indexBits = 4
) (
	input  logic clock,
	input  logic reset,

	// pipeline request
	input  logic ren,
	input  logic wen,
	input  logic [dataCachePkg::wordBits-1:0] addr,
	input  logic [dataCachePkg::byteLanes-1:0] byteSelect,
	input  logic [dataCachePkg::wordBits-1:0] din,

	// controller strobes
	input  logic fillEn,
	input  logic writeBack,

	// block returned by memory
	input  dataCachePkg::blockData memDout,

	// line status
	output logic cacheHit,
	output logic cacheDirty,

	// read data for the pipeline
	output logic [dataCachePkg::wordBits-1:0] dout,

	// memory side
	output logic [dataCachePkg::blockAddrBits-1:0] memBlockAddr,
	output dataCachePkg::blockData memDin
);

	import dataCachePkg::*;

	localparam int numLines = 2 ** indexBits;
	localparam int tagBits = wordBits - indexBits - offsetBits;
	localparam int laneBits = $clog2(byteLanes);
	localparam int wordSelBits = offsetBits - laneBits;

	// storage
	logic [numLines-1:0] validBits;
	logic [numLines-1:0] dirtyBits;
	logic [tagBits-1:0] tagArray [numLines];
	blockData dataArray [numLines];

	// address fields
	logic [tagBits-1:0] reqTag;
	logic [indexBits-1:0] reqIndex;
	logic [wordSelBits-1:0] reqWord;

	// addressed line
	logic [tagBits-1:0] lineTag;
	logic lineValid;
	blockData lineBlock;

	// block returned by memory, captured for the fill cycle
	blockData fillBlock;

	logic writeHit;
	blockData mergedBlock;

	assign reqTag = addr[wordBits-1 -: tagBits];
	assign reqIndex = addr[offsetBits +: indexBits];
	assign reqWord = addr[offsetBits-1:laneBits];

	assign lineTag = tagArray[reqIndex];
	assign lineValid = validBits[reqIndex];
	assign lineBlock = dataArray[reqIndex];

	// hit only counts with a request present
	assign cacheHit = (ren || wen) && lineValid && (lineTag == reqTag);
	assign cacheDirty = lineValid && dirtyBits[reqIndex];

	assign writeHit = wen && cacheHit;

	// read word out of the block
	assign dout = lineBlock.words[reqWord];

	// victim address during writeback, else the requested block
	assign memBlockAddr = writeBack ? {lineTag, reqIndex} : addr[wordBits-1:offsetBits];
	assign memDin = lineBlock;

	// replace only the selected bytes of the addressed word
	always_comb begin
		mergedBlock = lineBlock;
		for (int lane = 0; lane < byteLanes; lane++) begin
			if (byteSelect[lane]) begin
				mergedBlock.bytes[reqWord * byteLanes + lane] = din[8 * lane +: 8];
			end
		end
	end

	// memDout is only valid in the memReadReady cycle
	// so the fill in the next cycle uses this copy
	always_ff @(posedge clock) begin
		fillBlock <= memDout;
	end

	// valid and dirty bits
	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			validBits <= '0;
			dirtyBits <= '0;
		end else if (fillEn) begin
			validBits[reqIndex] <= 1'b1;
			dirtyBits[reqIndex] <= 1'b0;
		end else if (writeHit) begin
			dirtyBits[reqIndex] <= 1'b1;
		end
	end

	// tag and data storage
	always_ff @(posedge clock) begin
		if (fillEn) begin
			tagArray[reqIndex] <= reqTag;
			dataArray[reqIndex] <= fillBlock;
		end else if (writeHit) begin
			dataArray[reqIndex] <= mergedBlock;
		end
	end

endmodule

/* src/cacheController.sv */
`timescale 1ns/1ps

module cacheController (
	input  logic clock,
	input  logic reset,

	// pipeline request
	input  logic ren,
	input  logic wen,

	// status of the addressed line
	input  logic cacheHit,
	input  logic cacheDirty,

	// memory responses, one-cycle pulses
	input  logic memReadReady,
	input  logic memWriteDone,

	// pipeline stall
	output logic stall,

	// memory request levels
	output logic memRen,
	output logic memWen,

	// array control
	output logic writeBack,
	output logic fillEn
);

	typedef enum logic [2:0] {
		IDLE      = 3'd0,
		MISS      = 3'd1,
		WRITEBACK = 3'd2,
		MEMREAD   = 3'd3,
		FILL      = 3'd4
	} stateType;

	stateType state;
	stateType nextState;

	logic request;

	assign request = ren || wen;

	// state register
	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			state <= IDLE;
		end else begin
			state <= nextState;
		end
	end

	// next state
	always_comb begin
		nextState = state;
		case (state)
			IDLE: begin
				if (request && !cacheHit) begin
					nextState = MISS;
				end
			end
			MISS: begin
				// old block must reach memory before it is replaced
				if (cacheDirty) begin
					nextState = WRITEBACK;
				end else begin
					nextState = MEMREAD;
				end
			end
			WRITEBACK: begin
				if (memWriteDone) begin
					nextState = MEMREAD;
				end
			end
			MEMREAD: begin
				if (memReadReady) begin
					nextState = FILL;
				end
			end
			FILL: begin
				// held request hits on return to idle
				nextState = IDLE;
			end
			default: begin
				nextState = IDLE;
			end
		endcase
	end

	// outputs follow the state
	// idle stall is the only one that looks at the request
	always_comb begin
		stall = 1'b0;
		memRen = 1'b0;
		memWen = 1'b0;
		writeBack = 1'b0;
		fillEn = 1'b0;
		case (state)
			IDLE: begin
				// miss stalls in its first cycle
				stall = request && !cacheHit;
			end
			MISS: begin
				stall = 1'b1;
			end
			WRITEBACK: begin
				stall = 1'b1;
				memWen = 1'b1;
				writeBack = 1'b1;
			end
			MEMREAD: begin
				stall = 1'b1;
				memRen = 1'b1;
			end
			FILL: begin
				stall = 1'b1;
				fillEn = 1'b1;
			end
			default: begin
				stall = 1'b1;
			end
		endcase
	end

endmodule

/* src/dataCachePkg.sv */
package dataCachePkg;

	// data word and byte address width
	localparam int wordBits = 32;

	// bytes per word, also the byte-select width
	localparam int byteLanes = 4;

	// words per cache block
	localparam int blockWords = 4;

	// bytes per cache block
	localparam int blockBytes = blockWords * byteLanes;

	// byte offset inside a block
	// bits 1:0 pick the byte and bits 3:2 pick the word
	localparam int offsetBits = 4;

	// memory block address is the byte address without its offset
	localparam int blockAddrBits = wordBits - offsetBits;

	// one block seen two ways
	// words for read-out and the memory bus, bytes for merging writes
	typedef union packed {
		logic [blockWords-1:0][wordBits-1:0] words;
		logic [blockBytes-1:0][7:0] bytes;
	} blockData;

endpackage
